/* common/gat_dims_pkg.sv */
package gat_dims_pkg;

  // Feature row geometry
  localparam int NUM_FEAT = 4;
  localparam int DATA_W = 8;

  // Job size, node 0 is the target itself
  localparam int MAX_NODES = 8;
  localparam int NODE_W = 3;
  localparam int CNT_W = 4;

  // Coefficient path
  localparam int COEF_W = 20;
  localparam int LRELU_SHIFT = 3;

  // Output buffering
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Config map: attention entries at 0..7, self half first
  localparam int CFG_ADDR_W = 4;
  localparam int ATTN_ENTRIES = 2 * NUM_FEAT;
  localparam int CFG_NODES_ADDR = 8;
  localparam int CFG_START_ADDR = 9;

endpackage

/* common/gat_types_pkg.sv */
package gat_types_pkg;

  // Signed feature or attention entry
  typedef logic signed [gat_dims_pkg::DATA_W-1:0] data_t;

  // Feature 0 in the low bits
  typedef logic [gat_dims_pkg::NUM_FEAT*gat_dims_pkg::DATA_W-1:0] wh_row_t;

  typedef logic signed [gat_dims_pkg::COEF_W-1:0] coef_t;

  typedef logic [gat_dims_pkg::NODE_W-1:0] node_t;
  typedef logic [gat_dims_pkg::CNT_W-1:0] cnt_t;
  typedef logic [gat_dims_pkg::CFG_ADDR_W-1:0] cfg_addr_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_RD_SELF,
    ENG_RD_NBR,
    ENG_COMPUTE,
    ENG_PUSH
  } engine_state_e;

  // Four-phase sender
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,
    PORT_WAIT_REL
  } port_state_e;

endpackage

/* rtl/wh_bram.sv */
`timescale 1ns/1ns

module wh_bram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  gat_types_pkg::node_t     waddr_i,
  input  gat_types_pkg::wh_row_t   wdata_i,
  input  gat_types_pkg::node_t     raddr_i,
  output gat_types_pkg::wh_row_t   rdata_o
);

  gat_types_pkg::wh_row_t mem [gat_dims_pkg::MAX_NODES];
  gat_types_pkg::wh_row_t rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* dmvm/attn_cfg_regs.sv */
`timescale 1ns/1ns

module attn_cfg_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_we_i,
  input  gat_types_pkg::cfg_addr_t          cfg_addr_i,
  input  gat_types_pkg::data_t              cfg_data_i,
  input  logic                              done_i,
  output logic                              start_o,
  output gat_types_pkg::data_t [gat_dims_pkg::ATTN_ENTRIES-1:0] attn_o,
  output gat_types_pkg::cnt_t               node_cnt_o,
  output logic                              busy_o
);

  gat_types_pkg::data_t [gat_dims_pkg::ATTN_ENTRIES-1:0] attn_q;
  gat_types_pkg::cnt_t node_cnt_q;
  gat_types_pkg::cnt_t node_cnt_sat;
  logic start_q;
  logic busy_q;
  logic wr_ok;

  // Config is frozen for the whole job
  assign wr_ok = cfg_we_i && !busy_q;

  assign node_cnt_sat = ($unsigned(cfg_data_i) > gat_dims_pkg::MAX_NODES) ?
                        gat_types_pkg::cnt_t'(gat_dims_pkg::MAX_NODES) :
                        cfg_data_i[gat_dims_pkg::CNT_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      attn_q <= '0;
      node_cnt_q <= '0;
      start_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (done_i) begin
        busy_q <= 1'b0;
      end
      if (wr_ok) begin
        for (int i = 0; i < gat_dims_pkg::ATTN_ENTRIES; i++) begin
          if (cfg_addr_i == gat_types_pkg::cfg_addr_t'(i)) begin
            attn_q[i] <= cfg_data_i;
          end
        end
        if (cfg_addr_i == gat_types_pkg::cfg_addr_t'(gat_dims_pkg::CFG_NODES_ADDR)) begin
          node_cnt_q <= node_cnt_sat;
        end
        if (cfg_addr_i == gat_types_pkg::cfg_addr_t'(gat_dims_pkg::CFG_START_ADDR)) begin
          start_q <= 1'b1;
          busy_q <= 1'b1;
        end
      end
    end
  end

  assign start_o = start_q;
  assign attn_o = attn_q;
  assign node_cnt_o = node_cnt_q;
  assign busy_o = busy_q;

endmodule

/* dmvm/dmvm_engine.sv */
`timescale 1ns/1ns

module dmvm_engine (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start_i,
  input  gat_types_pkg::data_t [gat_dims_pkg::ATTN_ENTRIES-1:0] attn_i,
  input  gat_types_pkg::cnt_t               node_cnt_i,
  output logic                              done_o,
  output gat_types_pkg::node_t              rd_addr_o,
  input  gat_types_pkg::wh_row_t            rd_data_i,
  output logic                              push_o,
  output gat_types_pkg::node_t              push_node_o,
  output gat_types_pkg::coef_t              push_coef_o,
  input  logic                              full_i
);

  gat_types_pkg::engine_state_e state_q;
  gat_types_pkg::node_t node_idx_q;
  gat_types_pkg::wh_row_t self_row_q;
  gat_types_pkg::coef_t self_dot;
  gat_types_pkg::coef_t nbr_dot;
  gat_types_pkg::coef_t dot_sum;
  gat_types_pkg::coef_t coef_d;
  gat_types_pkg::coef_t coef_q;
  logic self_vld_q;
  logic done_q;
  logic last_node;

  // Self half uses entries 0..3, neighbour half entries 4..7
  always_comb begin
    self_dot = '0;
    nbr_dot = '0;
    for (int i = 0; i < gat_dims_pkg::NUM_FEAT; i++) begin
      self_dot = self_dot
        + gat_types_pkg::coef_t'($signed(self_row_q[i*gat_dims_pkg::DATA_W +: gat_dims_pkg::DATA_W]))
        * gat_types_pkg::coef_t'($signed(attn_i[i]));
      nbr_dot = nbr_dot
        + gat_types_pkg::coef_t'($signed(rd_data_i[i*gat_dims_pkg::DATA_W +: gat_dims_pkg::DATA_W]))
        * gat_types_pkg::coef_t'($signed(attn_i[gat_dims_pkg::NUM_FEAT+i]));
    end
  end

  assign dot_sum = self_dot + nbr_dot;

  // LeakyReLU with a power-of-two slope
  assign coef_d = dot_sum[gat_dims_pkg::COEF_W-1] ? (dot_sum >>> gat_dims_pkg::LRELU_SHIFT) :
                  dot_sum;

  assign last_node = (gat_types_pkg::cnt_t'(node_idx_q) + gat_types_pkg::cnt_t'(1)) == node_cnt_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= gat_types_pkg::ENG_IDLE;
      node_idx_q <= '0;
      self_vld_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        gat_types_pkg::ENG_IDLE: begin
          if (start_i) begin
            node_idx_q <= '0;
            self_vld_q <= 1'b0;
            if (node_cnt_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= gat_types_pkg::ENG_RD_SELF;
            end
          end
        end
        // Row 0 address out, then row 0 data back
        gat_types_pkg::ENG_RD_SELF: begin
          self_vld_q <= 1'b1;
          if (self_vld_q) begin
            state_q <= gat_types_pkg::ENG_RD_NBR;
          end
        end
        gat_types_pkg::ENG_RD_NBR: begin
          state_q <= gat_types_pkg::ENG_COMPUTE;
        end
        gat_types_pkg::ENG_COMPUTE: begin
          state_q <= gat_types_pkg::ENG_PUSH;
        end
        gat_types_pkg::ENG_PUSH: begin
          // Stall here on back-pressure
          if (!full_i) begin
            if (last_node) begin
              done_q <= 1'b1;
              state_q <= gat_types_pkg::ENG_IDLE;
            end else begin
              node_idx_q <= node_idx_q + 1'b1;
              state_q <= gat_types_pkg::ENG_RD_NBR;
            end
          end
        end
        default: begin
          state_q <= gat_types_pkg::ENG_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == gat_types_pkg::ENG_RD_SELF && self_vld_q) begin
      self_row_q <= rd_data_i;
    end
    if (state_q == gat_types_pkg::ENG_COMPUTE) begin
      coef_q <= coef_d;
    end
  end

  assign rd_addr_o = node_idx_q;
  assign done_o = done_q;
  assign push_o = (state_q == gat_types_pkg::ENG_PUSH) && !full_i;
  assign push_node_o = node_idx_q;
  assign push_coef_o = coef_q;

endmodule

/* rtl/coef_fifo.sv */
`timescale 1ns/1ns

module coef_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  gat_types_pkg::node_t   node_i,
  input  gat_types_pkg::coef_t   coef_i,
  input  logic                   pop_i,
  output gat_types_pkg::node_t   node_o,
  output gat_types_pkg::coef_t   coef_o,
  output logic                   empty_o,
  output logic                   full_o
);

  gat_types_pkg::node_t node_mem [gat_dims_pkg::FIFO_DEPTH];
  gat_types_pkg::coef_t coef_mem [gat_dims_pkg::FIFO_DEPTH];
  logic [gat_dims_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [gat_dims_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [gat_dims_pkg::FIFO_PTR_W:0] count_q;
  logic do_push;
  logic do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      // Depth is a power of two so the pointers wrap by themselves
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{gat_dims_pkg::FIFO_PTR_W{1'b0}}, do_push}
                         - {{gat_dims_pkg::FIFO_PTR_W{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      node_mem[wr_ptr_q] <= node_i;
      coef_mem[wr_ptr_q] <= coef_i;
    end
  end

  assign node_o = node_mem[rd_ptr_q];
  assign coef_o = coef_mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o = (count_q == (gat_dims_pkg::FIFO_PTR_W+1)'(gat_dims_pkg::FIFO_DEPTH));

endmodule

/* rtl/coef_out_port.sv */
`timescale 1ns/1ns

module coef_out_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   empty_i,
  input  gat_types_pkg::node_t   node_i,
  input  gat_types_pkg::coef_t   coef_i,
  output logic                   pop_o,
  output logic                   req_o,
  output gat_types_pkg::node_t   node_o,
  output gat_types_pkg::coef_t   coef_o,
  input  logic                   ack_i
);

  gat_types_pkg::port_state_e state_q;
  gat_types_pkg::node_t node_q;
  gat_types_pkg::coef_t coef_q;

  // Take the head entry as the port leaves idle
  assign pop_o = (state_q == gat_types_pkg::PORT_IDLE) && !empty_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= gat_types_pkg::PORT_IDLE;
    end else begin
      case (state_q)
        gat_types_pkg::PORT_IDLE: begin
          if (!empty_i) begin
            state_q <= gat_types_pkg::PORT_REQ;
          end
        end
        gat_types_pkg::PORT_REQ: begin
          if (ack_i) begin
            state_q <= gat_types_pkg::PORT_WAIT_REL;
          end
        end
        // Next req only once ack is back low
        gat_types_pkg::PORT_WAIT_REL: begin
          if (!ack_i) begin
            state_q <= gat_types_pkg::PORT_IDLE;
          end
        end
        default: begin
          state_q <= gat_types_pkg::PORT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      node_q <= node_i;
      coef_q <= coef_i;
    end
  end

  assign req_o = (state_q == gat_types_pkg::PORT_REQ);
  assign node_o = node_q;
  assign coef_o = coef_q;

endmodule

/* rtl/gat_dmvm_top.sv */
`timescale 1ns/1ns

module gat_dmvm_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wh_we_i,
  input  gat_types_pkg::node_t        wh_addr_i,
  input  gat_types_pkg::wh_row_t      wh_data_i,
  input  logic                        cfg_we_i,
  input  gat_types_pkg::cfg_addr_t    cfg_addr_i,
  input  gat_types_pkg::data_t        cfg_data_i,
  output logic                        busy_o,
  output logic                        coef_req_o,
  output gat_types_pkg::node_t        coef_node_o,
  output gat_types_pkg::coef_t        coef_o,
  input  logic                        coef_ack_i
);

  gat_types_pkg::data_t [gat_dims_pkg::ATTN_ENTRIES-1:0] attn;
  gat_types_pkg::cnt_t node_cnt;
  gat_types_pkg::node_t rd_addr;
  gat_types_pkg::wh_row_t rd_data;
  gat_types_pkg::node_t push_node;
  gat_types_pkg::coef_t push_coef;
  gat_types_pkg::node_t head_node;
  gat_types_pkg::coef_t head_coef;
  logic start;
  logic done;
  logic push;
  logic pop;
  logic fifo_empty;
  logic fifo_full;

  wh_bram u_wh_bram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (wh_we_i),
    .waddr_i (wh_addr_i),
    .wdata_i (wh_data_i),
    .raddr_i (rd_addr),
    .rdata_o (rd_data)
  );

  attn_cfg_regs u_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .done_i     (done),
    .start_o    (start),
    .attn_o     (attn),
    .node_cnt_o (node_cnt),
    .busy_o     (busy_o)
  );

  dmvm_engine u_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .attn_i      (attn),
    .node_cnt_i  (node_cnt),
    .done_o      (done),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .push_o      (push),
    .push_node_o (push_node),
    .push_coef_o (push_coef),
    .full_i      (fifo_full)
  );

  coef_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (push),
    .node_i  (push_node),
    .coef_i  (push_coef),
    .pop_i   (pop),
    .node_o  (head_node),
    .coef_o  (head_coef),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  coef_out_port u_out (
    .clk     (clk),
    .rst_n   (rst_n),
    .empty_i (fifo_empty),
    .node_i  (head_node),
    .coef_i  (head_coef),
    .pop_o   (pop),
    .req_o   (coef_req_o),
    .node_o  (coef_node_o),
    .coef_o  (coef_o),
    .ack_i   (coef_ack_i)
  );

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* tests/gat_dmvm_tb.sv */
`timescale 1ns/1ns

module gat_dmvm_tb;

  localparam int unsigned SEED = 32'h31e0_646e;
  localparam int REQ_TIMEOUT = 400;
  localparam int IDLE_TIMEOUT = 400;
  localparam int RST_TIMEOUT = 20;
  localparam int NF = gat_dims_pkg::NUM_FEAT;
  localparam int DW = gat_dims_pkg::DATA_W;

  logic clk;
  logic rst_n;
  logic wh_we;
  gat_types_pkg::node_t wh_addr;
  gat_types_pkg::wh_row_t wh_data;
  logic cfg_we;
  gat_types_pkg::cfg_addr_t cfg_addr;
  gat_types_pkg::data_t cfg_data;
  logic busy;
  logic coef_req;
  gat_types_pkg::node_t coef_node;
  gat_types_pkg::coef_t coef;
  logic coef_ack;

  // Host-side copy of the WH rows and attention entries
  gat_types_pkg::wh_row_t model_wh [gat_dims_pkg::MAX_NODES];
  int model_attn [gat_dims_pkg::ATTN_ENTRIES];
  int value_errs;
  int proto_errs;

  tb_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_dmvm_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_we_i    (wh_we),
    .wh_addr_i  (wh_addr),
    .wh_data_i  (wh_data),
    .cfg_we_i   (cfg_we),
    .cfg_addr_i (cfg_addr),
    .cfg_data_i (cfg_data),
    .busy_o     (busy),
    .coef_req_o (coef_req),
    .coef_node_o(coef_node),
    .coef_o     (coef),
    .coef_ack_i (coef_ack)
  );

  function automatic int random_value(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo, 0));
  endfunction

  function automatic gat_types_pkg::wh_row_t random_row(input int lo, input int hi);
    gat_types_pkg::wh_row_t row;
    for (int i = 0; i < NF; i++) begin
      row[i*DW +: DW] = gat_types_pkg::data_t'(random_value(lo, hi));
    end
    return row;
  endfunction

  function automatic int feature(input gat_types_pkg::wh_row_t row, input int i);
    gat_types_pkg::data_t f;
    f = row[i*DW +: DW];
    return int'(f);
  endfunction

  // Self half against row 0, neighbour half against row j
  function automatic int expected_coef(input int j);
    int sum;
    sum = 0;
    for (int i = 0; i < NF; i++) begin
      sum += feature(model_wh[0], i) * model_attn[i];
      sum += feature(model_wh[j], i) * model_attn[NF + i];
    end
    if (sum < 0) begin
      sum = sum >>> gat_dims_pkg::LRELU_SHIFT;
    end
    return sum;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    proto_errs++;
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic write_row(input int idx, input gat_types_pkg::wh_row_t row);
    wh_we = 1'b1;
    wh_addr = gat_types_pkg::node_t'(idx);
    wh_data = row;
    model_wh[idx] = row;
    tick();
    wh_we = 1'b0;
  endtask

  task automatic cfg_write(input int addr, input int data);
    cfg_we = 1'b1;
    cfg_addr = gat_types_pkg::cfg_addr_t'(addr);
    cfg_data = gat_types_pkg::data_t'(data);
    tick();
    cfg_we = 1'b0;
  endtask

  task automatic set_attn(input int lo, input int hi);
    int v;
    for (int i = 0; i < gat_dims_pkg::ATTN_ENTRIES; i++) begin
      v = random_value(lo, hi);
      model_attn[i] = v;
      cfg_write(i, v);
    end
  endtask

  task automatic start_job(input int cnt);
    cfg_write(gat_dims_pkg::CFG_NODES_ADDR, cnt);
    cfg_write(gat_dims_pkg::CFG_START_ADDR, 0);
    if (!busy) begin
      $display("busy_o did not rise after the start command");
      proto_errs++;
    end
  endtask

  task automatic expect_quiet(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      tick();
      if (coef_req) begin
        $display("Request seen with no transfer pending");
        proto_errs++;
      end
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy && waited < IDLE_TIMEOUT) begin
      tick();
      waited++;
    end
    if (busy) begin
      abort_run("busy_o stayed high after the job");
    end
  endtask

  // One four-phase transfer, acked after a random delay
  task automatic receive_coef(input int k, input int dmin, input int dmax);
    int waited;
    int dly;
    gat_types_pkg::node_t got_node;
    gat_types_pkg::coef_t got_coef;
    gat_types_pkg::coef_t exp_coef;
    waited = 0;
    while (!coef_req && waited < REQ_TIMEOUT) begin
      tick();
      waited++;
    end
    if (!coef_req) begin
      abort_run("no coefficient request from the DUT");
    end
    got_node = coef_node;
    got_coef = coef;
    exp_coef = gat_types_pkg::coef_t'(expected_coef(k));
    if (got_node != gat_types_pkg::node_t'(k)) begin
      $display("Error: coef_node_o = %h, expected %h", got_node, gat_types_pkg::node_t'(k));
      value_errs++;
    end
    if (got_coef != exp_coef) begin
      $display("Error: coef_o = %h, expected %h (node %0d)", got_coef, exp_coef, k);
      value_errs++;
    end
    dly = random_value(dmin, dmax);
    for (int c = 0; c < dly; c++) begin
      tick();
      if (!coef_req || coef_node != got_node || coef != got_coef) begin
        $display("Request dropped or its data changed before ack, node %0d", k);
        proto_errs++;
      end
    end
    coef_ack = 1'b1;
    tick();
    waited = 0;
    while (coef_req && waited < REQ_TIMEOUT) begin
      tick();
      waited++;
    end
    if (coef_req) begin
      abort_run("request stayed high after ack");
    end
    coef_ack = 1'b0;
  endtask

  task automatic finish_job(input int n, input int dmin, input int dmax);
    for (int k = 0; k < n; k++) begin
      receive_coef(k, dmin, dmax);
    end
    wait_idle();
    expect_quiet(8);
  endtask

  task automatic random_rows(input int lo, input int hi);
    for (int r = 0; r < gat_dims_pkg::MAX_NODES; r++) begin
      write_row(r, random_row(lo, hi));
    end
  endtask

  initial begin
    int waited;
    int n;
    wh_we = 1'b0;
    wh_addr = '0;
    wh_data = '0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    coef_ack = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    void'($urandom(SEED));

    waited = 0;
    while (!rst_n && waited < RST_TIMEOUT) begin
      tick();
      waited++;
    end
    if (!rst_n) begin
      abort_run("reset was never released");
    end
    if (coef_req) begin
      $display("Error: coef_req_o = %h after reset, expected 0", coef_req);
      value_errs++;
    end
    if (busy) begin
      $display("Error: busy_o = %h after reset, expected 0", busy);
      value_errs++;
    end
    expect_quiet(10);

    random_rows(-128, 127);
    for (int job = 0; job < 20; job++) begin
      n = random_value(1, gat_dims_pkg::MAX_NODES);
      for (int r = 0; r < n; r++) begin
        write_row(r, random_row(-128, 127));
      end
      set_attn(-128, 127);
      start_job(n);
      finish_job(n, 0, 6);
    end

    // Slow host, FIFO fills and the engine stalls
    random_rows(-128, 127);
    set_attn(-128, 127);
    start_job(8);
    finish_job(8, 12, 20);

    // Positive rows with negative attention give negative sums
    random_rows(1, 127);
    set_attn(-128, -1);
    start_job(8);
    finish_job(8, 0, 6);

    // Writes during busy are ignored
    random_rows(-128, 127);
    set_attn(-128, 127);
    start_job(8);
    for (int i = 0; i < gat_dims_pkg::ATTN_ENTRIES; i++) begin
      cfg_write(i, random_value(-128, 127));
    end
    cfg_write(gat_dims_pkg::CFG_NODES_ADDR, 3);
    cfg_write(gat_dims_pkg::CFG_START_ADDR, 0);
    finish_job(8, 0, 6);

    // Empty job
    start_job(0);
    wait_idle();
    expect_quiet(10);

    // Count above the limit saturates
    start_job(12);
    finish_job(8, 0, 3);

    // Rewritten rows show up in the next job
    write_row(0, random_row(-128, 127));
    write_row(3, random_row(-128, 127));
    write_row(6, random_row(-128, 127));
    start_job(8);
    finish_job(8, 0, 6);

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* gat_dmvm_top.f */
common/gat_dims_pkg.sv
common/gat_types_pkg.sv
rtl/wh_bram.sv
dmvm/attn_cfg_regs.sv
dmvm/dmvm_engine.sv
rtl/coef_fifo.sv
rtl/coef_out_port.sv
rtl/gat_dmvm_top.sv
tests/tb_clk_gen.sv
tests/gat_dmvm_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run gat_dmvm_tb, check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module gat_dmvm_tb \
		-f gat_dmvm_top.f -Mdir obj_dir -o gat_dmvm_sim
	./obj_dir/gat_dmvm_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
